//--- verilog/riscv_isa_pkg.sv
package riscv_isa_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7, also the upper immediate bits of the shift-immediate forms
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // Same 32-bit word, three field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
    } instr_word_u;

endpackage

//--- verilog/core_pipe_pkg.sv
package core_pipe_pkg;

    // Datapath width
    localparam int XLEN = 32;

    // Register index width, wide enough for 32 registers
    localparam int REG_ADDR_W = 5;

    ////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // Second operand straight through, for LUI
        ALU_PASS_B
    } alu_op_e;

endpackage

//--- verilog/decode_exec_if.sv
`timescale 1ns/1ps

interface decode_exec_if;
    import core_pipe_pkg::*;

    // One decoded operation per strobe
    logic                  valid;
    alu_op_e               alu_op;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic                  use_imm;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_write;

    modport decode (
        output valid, alu_op, rs1, rs2, imm, use_imm, rd, rd_write
    );

    modport execute (
        input valid, alu_op, rs1, rs2, imm, use_imm, rd, rd_write
    );

endinterface

//--- verilog/instr_decode.sv
`timescale 1ns/1ps

module instr_decode #(
    parameter int REG_COUNT = 32
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 instr_valid,
    input  logic [31:0]          instr,
    output logic                 illegal_instr,
    decode_exec_if.decode        dx
);
    import riscv_isa_pkg::*;
    import core_pipe_pkg::*;

    instr_word_u           iw;
    alu_op_e               alu_op_c;
    logic [XLEN-1:0]       imm_c;
    logic                  use_imm_c;
    logic [REG_ADDR_W-1:0] rs1_c;
    logic [REG_ADDR_W-1:0] rs2_c;
    logic [REG_ADDR_W-1:0] rd_c;
    logic                  known_c;
    logic                  legal_c;

    // Operation picked by funct3 alone, when funct7 is all zero
    function automatic alu_op_e base_op(input logic [2:0] f3);
        case (f3)
            F3_ADD_SUB: return ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    function automatic logic reg_ok(input logic [REG_ADDR_W-1:0] idx);
        return int'(idx) < REG_COUNT;
    endfunction

    assign iw = instr;

    ////////////////////////////////////////
    // Field decode
    ////////////////////////////////////////

    always_comb
    begin
        alu_op_c  = ALU_ADD;
        imm_c     = '0;
        use_imm_c = 1'b0;
        rs1_c     = '0;
        rs2_c     = '0;
        rd_c      = iw.r.rd;
        known_c   = 1'b0;
        case (iw.r.opcode)
            OPC_OP:
            begin
                rs1_c = iw.r.rs1;
                rs2_c = iw.r.rs2;
                if (iw.r.funct7 == F7_BASE)
                begin
                    alu_op_c = base_op(iw.r.funct3);
                    known_c  = 1'b1;
                end
                else if (iw.r.funct7 == F7_ALT && iw.r.funct3 == F3_ADD_SUB)
                begin
                    alu_op_c = ALU_SUB;
                    known_c  = 1'b1;
                end
                else if (iw.r.funct7 == F7_ALT && iw.r.funct3 == F3_SRL_SRA)
                begin
                    alu_op_c = ALU_SRA;
                    known_c  = 1'b1;
                end
            end
            OPC_OP_IMM:
            begin
                rs1_c     = iw.i.rs1;
                imm_c     = {{(XLEN-12){iw.i.imm[11]}}, iw.i.imm};
                use_imm_c = 1'b1;
                alu_op_c  = base_op(iw.i.funct3);
                // Shift forms keep a funct7 in the upper immediate bits
                if (iw.i.funct3 == F3_SLL)
                    known_c = (iw.i.imm[11:5] == F7_BASE);
                else if (iw.i.funct3 == F3_SRL_SRA)
                begin
                    known_c = (iw.i.imm[11:5] == F7_BASE) || (iw.i.imm[11:5] == F7_ALT);
                    if (iw.i.imm[11:5] == F7_ALT)
                        alu_op_c = ALU_SRA;
                end
                else
                    known_c = 1'b1;
            end
            OPC_LUI:
            begin
                imm_c     = {iw.u.imm, 12'h000};
                use_imm_c = 1'b1;
                alu_op_c  = ALU_PASS_B;
                known_c   = 1'b1;
            end
            default:
            begin
                known_c = 1'b0;
            end
        endcase
    end

    // Unused source indices are zero, so checking all three is safe
    assign legal_c = known_c && reg_ok(rd_c) && reg_ok(rs1_c) && reg_ok(rs2_c);

    ////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            dx.valid      <= 1'b0;
            illegal_instr <= 1'b0;
        end
        else
        begin
            dx.valid      <= instr_valid && legal_c;
            illegal_instr <= instr_valid && !legal_c;
        end
    end

    always_ff @(posedge clk)
    begin
        if (instr_valid && legal_c)
        begin
            dx.alu_op   <= alu_op_c;
            dx.rs1      <= rs1_c;
            dx.rs2      <= rs2_c;
            dx.imm      <= imm_c;
            dx.use_imm  <= use_imm_c;
            dx.rd       <= rd_c;
            dx.rd_write <= (rd_c != '0); // x0 writes die here
        end
    end

endmodule

//--- verilog/alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
    input  logic                                clk,
    input  logic                                arst_n,
    decode_exec_if.execute                      dx,
    output logic [core_pipe_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [core_pipe_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [core_pipe_pkg::XLEN-1:0]       rs1_data,
    input  logic [core_pipe_pkg::XLEN-1:0]       rs2_data,
    output logic                                res_valid,
    output logic [core_pipe_pkg::REG_ADDR_W-1:0] res_rd,
    output logic [core_pipe_pkg::XLEN-1:0]       res_data
);
    import core_pipe_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_c;

    assign rs1_addr = dx.rs1;
    assign rs2_addr = dx.rs2;

    ////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////

    // Previous op is still in the result register, older ones are in the file
    assign op_a    = (res_valid && res_rd == dx.rs1) ? res_data : rs1_data;
    assign rs2_fwd = (res_valid && res_rd == dx.rs2) ? res_data : rs2_data;
    assign op_b    = dx.use_imm ? dx.imm : rs2_fwd;
    assign shamt   = op_b[4:0];

    always_comb
    begin
        case (dx.alu_op)
            ALU_ADD:    alu_c = op_a + op_b;
            ALU_SUB:    alu_c = op_a - op_b;
            ALU_SLL:    alu_c = op_a << shamt;
            ALU_SLT:    alu_c = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_c = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_c = op_a ^ op_b;
            ALU_SRL:    alu_c = op_a >> shamt;
            ALU_SRA:    alu_c = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_c = op_a | op_b;
            ALU_AND:    alu_c = op_a & op_b;
            ALU_PASS_B: alu_c = op_b;
            default:    alu_c = '0;
        endcase
    end

    ////////////////////////////////////////
    // Result register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            res_valid <= 1'b0;
        else
            res_valid <= dx.valid && dx.rd_write;
    end

    always_ff @(posedge clk)
    begin
        if (dx.valid && dx.rd_write)
        begin
            res_rd   <= dx.rd;
            res_data <= alu_c;
        end
    end

endmodule

//--- verilog/retire_stage.sv
`timescale 1ns/1ps

module retire_stage #(
    parameter int REG_COUNT = 32
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                res_valid,
    input  logic [core_pipe_pkg::REG_ADDR_W-1:0] res_rd,
    input  logic [core_pipe_pkg::XLEN-1:0]       res_data,
    input  logic [core_pipe_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [core_pipe_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [core_pipe_pkg::XLEN-1:0]       rs1_data,
    output logic [core_pipe_pkg::XLEN-1:0]       rs2_data,
    output logic                                wb_valid,
    output logic [core_pipe_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [core_pipe_pkg::XLEN-1:0]       wb_data
);
    import core_pipe_pkg::*;

    // Bits actually needed to index REG_COUNT entries
    localparam int IDX_W = $clog2(REG_COUNT);

    logic [XLEN-1:0] regs [REG_COUNT];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd1_idx;
    logic [IDX_W-1:0] rd2_idx;

    // Decode has already rejected indices beyond the file
    assign wr_idx  = res_rd[IDX_W-1:0];
    assign rd1_idx = rs1_addr[IDX_W-1:0];
    assign rd2_idx = rs2_addr[IDX_W-1:0];

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////

    // Entry 0 is never written, so it stays zero after reset
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (res_valid)
        begin
            regs[wr_idx] <= res_data;
        end
    end

    // Combinational read ports for execute
    assign rs1_data = regs[rd1_idx];
    assign rs2_data = regs[rd2_idx];

    ////////////////////////////////////////
    // Write-back event
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= res_valid;
    end

    // Same edge as the file write
    always_ff @(posedge clk)
    begin
        if (res_valid)
        begin
            wb_rd   <= res_rd;
            wb_data <= res_data;
        end
    end

endmodule

//--- verilog/mini_rv_core.sv
`timescale 1ns/1ps

module mini_rv_core #(
    parameter int REG_COUNT = 32
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                instr_valid,
    input  logic [31:0]                         instr,
    output logic                                wb_valid,
    output logic [core_pipe_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [core_pipe_pkg::XLEN-1:0]       wb_data,
    output logic                                illegal_instr
);
    import core_pipe_pkg::*;

    // Execute to retire
    logic                  res_valid;
    logic [REG_ADDR_W-1:0] res_rd;
    logic [XLEN-1:0]       res_data;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    decode_exec_if dx_if ();

    instr_decode #(
        .REG_COUNT (REG_COUNT)
    ) instr_decode_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .illegal_instr (illegal_instr),
        .dx            (dx_if.decode)
    );

    alu_execute alu_execute_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .dx        (dx_if.execute),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .res_valid (res_valid),
        .res_rd    (res_rd),
        .res_data  (res_data)
    );

    retire_stage #(
        .REG_COUNT (REG_COUNT)
    ) retire_stage_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .res_valid (res_valid),
        .res_rd    (res_rd),
        .res_data  (res_data),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

endmodule

//--- testbench/mini_rv_core_asserts.sv
`timescale 1ns/1ps

module mini_rv_core_asserts (
    input logic                                clk,
    input logic                                arst_n,
    input logic                                instr_valid,
    input logic                                wb_valid,
    input logic [core_pipe_pkg::REG_ADDR_W-1:0] wb_rd,
    input logic                                illegal_instr
);

    int fail_count = 0;

    // Outputs quiet while reset is held
    reset_quiet: assert property (@(posedge clk) !arst_n |-> (!wb_valid && !illegal_instr))
    else
    begin
        $error("wb_valid or illegal_instr high during reset");
        fail_count++;
    end

    // x0 writes never reach the write-back port
    wb_rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> (wb_rd != '0))
    else
    begin
        $error("write-back to register zero");
        fail_count++;
    end

    // Three edges from accept to write-back
    wb_latency: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> $past(instr_valid, 3))
    else
    begin
        $error("wb_valid without an instruction three cycles earlier");
        fail_count++;
    end

endmodule

bind mini_rv_core mini_rv_core_asserts asserts_inst (
    .clk           (clk),
    .arst_n        (arst_n),
    .instr_valid   (instr_valid),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .illegal_instr (illegal_instr)
);

//--- testbench/mini_rv_core_tb.sv
`timescale 1ns/1ps

module mini_rv_core_tb;
    import riscv_isa_pkg::*;
    import core_pipe_pkg::*;

    localparam int REG_COUNT  = 32;
    localparam int NUM_INSTR  = 400;
    // 400 instructions at up to 4 cycles each, plus reset and drain
    localparam int MAX_CYCLES = 2000;

    logic                  clk;
    logic                  arst_n;
    logic                  instr_valid;
    logic [31:0]           instr;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic                  illegal_instr;

    integer                seed;
    int                    error_count;
    int                    check_count;
    int                    cycle_count;
    int                    wb_count;
    int                    illegal_seen;
    int                    illegal_expected;
    logic [XLEN-1:0]       model_regs [32];
    logic [REG_ADDR_W-1:0] exp_rd_q [$];
    logic [XLEN-1:0]       exp_data_q [$];

    mini_rv_core #(
        .REG_COUNT (REG_COUNT)
    ) mini_rv_core_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .illegal_instr (illegal_instr)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            error_count++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // Half the picks land in x0..x7 so that dependent pairs are frequent
    function automatic logic [REG_ADDR_W-1:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        if (r[31])
            return REG_ADDR_W'(r[2:0]);
        return REG_ADDR_W'(r % REG_COUNT);
    endfunction

    ////////////////////////////////////////
    // Instruction generator
    ////////////////////////////////////////

    function automatic logic [31:0] gen_instr();
        logic [31:0]           r;
        logic [3:0]            kind;
        logic [2:0]            f3;
        logic [6:0]            f7;
        logic [11:0]           imm12;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        r     = next_rand();
        kind  = r[3:0];
        f3    = r[6:4];
        imm12 = r[27:16];
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        if (kind < 4'd6)
        begin
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[15]) ? F7_ALT : F7_BASE;
            return {f7, rs2, rs1, f3, rd, OPC_OP};
        end
        if (kind < 4'd12)
        begin
            if (f3 == 3'd1)
                imm12[11:5] = F7_BASE;
            else if (f3 == 3'd5)
                imm12[11:5] = r[15] ? F7_ALT : F7_BASE;
            return {imm12, rs1, f3, rd, OPC_OP_IMM};
        end
        if (kind < 4'd14)
            return {next_rand() & 32'hffff_f000} | {20'h0, rd, OPC_LUI};
        // Load opcode, not supported here
        if (kind == 4'd14)
            return {r[31:7], 7'b0000011};
        // Multiply-extension funct7
        return {7'b0000001, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic apply_model(input logic [31:0] w);
        logic [6:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] result;
        logic        legal;
        opcode = w[6:0];
        rd     = w[11:7];
        f3     = w[14:12];
        rs1    = w[19:15];
        rs2    = w[24:20];
        f7     = w[31:25];
        legal  = 1'b1;
        result = '0;
        case (opcode)
            OPC_OP:
            begin
                if (!(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))))
                    legal = 1'b0;
                if (int'(rs1) >= REG_COUNT || int'(rs2) >= REG_COUNT)
                    legal = 1'b0;
                result = alu_ref(f3, f7[5], model_regs[rs1], model_regs[rs2]);
            end
            OPC_OP_IMM:
            begin
                if (f3 == 3'd1 && f7 != 7'h00)
                    legal = 1'b0;
                if (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)
                    legal = 1'b0;
                if (int'(rs1) >= REG_COUNT)
                    legal = 1'b0;
                result = alu_ref(f3, (f3 == 3'd5) && f7[5], model_regs[rs1],
                                 {{20{w[31]}}, w[31:20]});
            end
            OPC_LUI:
                result = {w[31:12], 12'h000};
            default:
                legal = 1'b0;
        endcase
        if (int'(rd) >= REG_COUNT)
            legal = 1'b0;
        if (!legal)
            illegal_expected++;
        else if (rd != 5'd0)
        begin
            model_regs[rd] = result;
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(result);
        end
    endtask

    ////////////////////////////////////////
    // Output monitors
    ////////////////////////////////////////

    always @(negedge clk)
    begin
        if (arst_n && wb_valid)
        begin
            wb_count++;
            if (exp_rd_q.size() == 0)
            begin
                error_count++;
                $display("Write-back to x%0d arrived with no result pending", wb_rd);
            end
            else
            begin
                compare_value("wb_rd", 32'(exp_rd_q.pop_front()), 32'(wb_rd));
                compare_value("wb_data", exp_data_q.pop_front(), wb_data);
            end
        end
        if (arst_n && illegal_instr)
            illegal_seen++;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    initial
    begin
        logic [31:0] word;
        logic [31:0] r;
        int          gap;
        seed             = 73;
        error_count      = 0;
        check_count      = 0;
        cycle_count      = 0;
        wb_count         = 0;
        illegal_seen     = 0;
        illegal_expected = 0;
        arst_n           = 1'b0;
        instr_valid      = 1'b0;
        instr            = '0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        for (int n = 0; n < NUM_INSTR; n++)
        begin
            @(negedge clk);
            word        = gen_instr();
            instr_valid = 1'b1;
            instr       = word;
            apply_model(word);
            r   = next_rand();
            gap = int'(r[1:0]);
            // Idle cycles carry junk on instr
            repeat (gap)
            begin
                @(negedge clk);
                instr_valid = 1'b0;
                instr       = next_rand();
            end
        end
        @(negedge clk);
        instr_valid = 1'b0;
        repeat (8) @(negedge clk);
        if (exp_rd_q.size() != 0)
        begin
            error_count++;
            $display("%0d expected write-backs never appeared", exp_rd_q.size());
        end
        compare_value("illegal_count", 32'(illegal_expected), 32'(illegal_seen));
        error_count += mini_rv_core_inst.asserts_inst.fail_count;
        $display("Done: %0d checks, %0d errors, %0d assertion failures, %0d write-backs",
                 check_count, error_count, mini_rv_core_inst.asserts_inst.fail_count,
                 wb_count);
        if (error_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- mini_rv_core.f
verilog/riscv_isa_pkg.sv
verilog/core_pipe_pkg.sv
verilog/decode_exec_if.sv
verilog/instr_decode.sv
verilog/alu_execute.sv
verilog/retire_stage.sv
verilog/mini_rv_core.sv
testbench/mini_rv_core_asserts.sv
testbench/mini_rv_core_tb.sv

//--- Makefile
# Verilator flow for the mini RV32I core

VERILATOR ?= verilator
TOP       ?= mini_rv_core_tb
FILELIST  ?= mini_rv_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= sim passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Pass only when the testbench prints the pass line
sim: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
